/* common/capture_pkg.sv */
`default_nettype none

package capture_pkg;

    typedef logic [15:0] pixel_t;      // rgb565
    typedef logic [31:0] word_t;       // even pixel in the lower half
    typedef logic [20:0] mem_addr_t;   // word address in external memory
    typedef logic [1:0]  cmd_t;

    localparam cmd_t CMD_FRAME_START = 2'd1;
    localparam cmd_t CMD_ROW_START   = 2'd2;
    localparam cmd_t CMD_FRAME_END   = 2'd3;

    localparam int FRAME_WIDTH    = 16;
    localparam int FRAME_HEIGHT   = 4;
    localparam int WORDS_PER_ROW  = FRAME_WIDTH / 2;
    localparam int BURST_WORDS    = 4;
    localparam int READ_LATENCY   = 2;
    localparam int CMD_FIFO_DEPTH = 4;
    localparam int CMD_PTR_W      = $clog2(CMD_FIFO_DEPTH);

    typedef logic [2:0] word_index_t;
    typedef logic [1:0] row_index_t;
    typedef logic [CMD_PTR_W-1:0] cmd_ptr_t;
    typedef logic [CMD_PTR_W:0]   cmd_count_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_FRAME_START,
        ST_WAIT_ROW_START,
        ST_REQUEST,
        ST_BURST,
        ST_RELEASE,
        ST_WAIT_FRAME_END,
        ST_DONE
    } uploader_state_t;

endpackage

`default_nettype wire

/* common/mem_burst_if.sv */
`default_nettype none

interface mem_burst_if
    import capture_pkg::*;
();
    logic      write_rq;    // held high for the whole grant
    logic      write_ack;   // level grant from the memory side
    logic      mem_wr_en;
    mem_addr_t write_addr;
    word_t     write_data;

    modport uploader (
        output write_rq, mem_wr_en, write_addr, write_data,
        input  write_ack
    );

    modport memory (
        input  write_rq, mem_wr_en, write_addr, write_data,
        output write_ack
    );

endinterface

`default_nettype wire

/* dv/capture_sva.sv */
`default_nettype none

module capture_sva
    import capture_pkg::*;
(
    input wire clk,
    input wire reset_n,
    input wire write_rq,
    input wire write_ack,
    input wire mem_wr_en,
    input wire upload_done
);

    int beat_run;      // length of the current run of beats
    int grant_beats;   // beats seen while write_rq is high

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_run    <= 0;
            grant_beats <= 0;
        end else begin
            beat_run    <= mem_wr_en ? beat_run + 1 : 0;
            grant_beats <= !write_rq ? 0 : grant_beats + (mem_wr_en ? 1 : 0);
        end
    end

    beat_in_grant: assert property (@(posedge clk) disable iff (!reset_n)
        mem_wr_en |-> (write_rq && write_ack))
        else $error("write beat outside a granted request");

    done_single: assert property (@(posedge clk) disable iff (!reset_n)
        upload_done |=> !upload_done)
        else $error("upload_done held for more than one cycle");

    beats_back_to_back: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(mem_wr_en) |-> (beat_run == BURST_WORDS))
        else $error("run of write beats has the wrong length");

    beats_per_grant: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(write_rq) |-> (grant_beats == BURST_WORDS))
        else $error("grant released with the wrong number of beats");

endmodule

`default_nettype wire

/* dv/capture_tb.sv */
`default_nettype none

module capture_tb
    import capture_pkg::*;
();

    typedef pixel_t [FRAME_HEIGHT-1:0][FRAME_WIDTH-1:0] frame_t;

    logic      clk;
    logic      reset_n;
    logic      start;
    mem_addr_t base_addr;
    logic      pixel_valid;
    pixel_t    pixel_data;
    logic      cmd_valid;
    cmd_t      cmd_code;
    logic      write_ack;
    logic      write_rq;
    mem_addr_t write_addr;
    logic      mem_wr_en;
    word_t     write_data;
    logic      upload_done;
    logic      cmd_overflow;

    frame_t    frame_pix;
    mem_addr_t cur_base;
    mem_addr_t exp_addr;
    word_t     exp_data;
    int        errors;
    int        beats;         // beats of the frame in progress
    int        total_beats;
    int        dones;
    int        tests;
    int        ack_wait;

    tb_clock u_clock (.clk(clk));

    capture_top dut (.*);

    bind frame_uploader capture_sva u_sva (
        .clk         (clk),
        .reset_n     (reset_n),
        .write_rq    (mem.write_rq),
        .write_ack   (mem.write_ack),
        .mem_wr_en   (mem.mem_wr_en),
        .upload_done (upload_done)
    );

    // word k of row r goes to base + r*WORDS_PER_ROW + k with the even pixel in the low half
    function automatic void expected_beat(
        input  mem_addr_t   base,
        input  frame_t      pix,
        input  row_index_t  row,
        input  word_index_t word_idx,
        output mem_addr_t   addr,
        output word_t       data
    );
        addr = base + mem_addr_t'(row) * mem_addr_t'(WORDS_PER_ROW) + mem_addr_t'(word_idx);
        data = {pix[row][{word_idx, 1'b1}], pix[row][{word_idx, 1'b0}]};
    endfunction

    // memory model grants 1 to 4 cycles after a request and releases once write_rq drops
    initial begin
        write_ack = 1'b0;
        ack_wait  = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset_n) begin
                write_ack = 1'b0;
                ack_wait  = 0;
            end else if (write_rq && !write_ack) begin
                if (ack_wait == 0) begin
                    ack_wait = int'($urandom_range(4, 1));
                end else begin
                    ack_wait--;
                    if (ack_wait == 0) begin
                        write_ack = 1'b1;
                    end
                end
            end else if (!write_rq && write_ack) begin
                write_ack = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (reset_n && mem_wr_en) begin
            if (beats >= FRAME_HEIGHT * WORDS_PER_ROW) begin
                errors++;
                $display("extra write beat at %0t after the frame was complete", $time);
            end else begin
                expected_beat(cur_base, frame_pix, row_index_t'(beats / WORDS_PER_ROW),
                              word_index_t'(beats % WORDS_PER_ROW), exp_addr, exp_data);
                if (write_addr !== exp_addr) begin
                    errors++;
                    $display("CHECK FAILED at %0t: write_addr expected %h, got %h",
                             $time, exp_addr, write_addr);
                end
                if (write_data !== exp_data) begin
                    errors++;
                    $display("CHECK FAILED at %0t: write_data expected %h, got %h",
                             $time, exp_data, write_data);
                end
            end
            beats++;
            total_beats++;
        end
        if (reset_n && upload_done) begin
            if (beats != FRAME_HEIGHT * WORDS_PER_ROW) begin
                errors++;
                $display("upload_done at %0t came after %0d beats, not after the last one",
                         $time, beats);
            end
            beats = 0;
            dones++;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        reset_n = 1'b0;
        repeat (8) next_cycle();
        reset_n = 1'b1;
        next_cycle();
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic send_cmd(input cmd_t code);
        cmd_valid = 1'b1;
        cmd_code  = code;
        next_cycle();
        cmd_valid = 1'b0;
    endtask

    task automatic feed_row(input int row);
        for (int p = 0; p < FRAME_WIDTH; p++) begin
            pixel_valid = 1'b1;
            pixel_data  = frame_pix[row_index_t'(row)][4'(p)];
            next_cycle();
        end
        pixel_valid = 1'b0;
    endtask

    task automatic wait_beats(input int count);
        int cycles = 0;
        while (beats < count && cycles < 200) begin
            next_cycle();
            cycles++;
        end
        if (beats < count) begin
            errors++;
            $display("timed out at %0t waiting for beat %0d, only %0d arrived",
                     $time, count, beats);
        end
    endtask

    task automatic wait_done(input int count);
        int cycles = 0;
        while (dones < count && cycles < 200) begin
            next_cycle();
            cycles++;
        end
        if (dones < count) begin
            errors++;
            $display("timed out at %0t waiting for upload_done of frame %0d", $time, count);
        end
    endtask

    // one frame of random pixels fed one row at a time so no bank is overwritten early
    task automatic run_frame(input mem_addr_t base, input logic strays);
        int frame_no = dones + 1;
        for (int r = 0; r < FRAME_HEIGHT; r++) begin
            for (int p = 0; p < FRAME_WIDTH; p++) begin
                frame_pix[row_index_t'(r)][4'(p)] = pixel_t'($urandom);
            end
        end
        cur_base  = base;
        base_addr = base;
        start     = 1'b1;
        next_cycle();
        start = 1'b0;
        if (strays) begin
            send_cmd(2'd0);
            send_cmd(CMD_ROW_START);
            send_cmd(CMD_FRAME_END);
        end
        send_cmd(CMD_FRAME_START);
        for (int r = 0; r < FRAME_HEIGHT; r++) begin
            feed_row(r);
            if (strays && r > 0) begin
                send_cmd(CMD_FRAME_END);   // wrong codes between rows
                send_cmd(2'd0);
            end
            send_cmd(CMD_ROW_START);
            wait_beats((r + 1) * WORDS_PER_ROW);
        end
        if (strays) begin
            send_cmd(CMD_ROW_START);
        end
        send_cmd(CMD_FRAME_END);
        wait_done(frame_no);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int errors_before;
        void'($urandom(21815));
        reset_n     = 1'b0;
        start       = 1'b0;
        base_addr   = '0;
        pixel_valid = 1'b0;
        pixel_data  = '0;
        cmd_valid   = 1'b0;
        cmd_code    = '0;
        errors      = 0;
        tests       = 0;

        errors_before = errors;
        apply_reset();
        check_bit("write_rq", write_rq, 1'b0);
        check_bit("mem_wr_en", mem_wr_en, 1'b0);
        check_bit("upload_done", upload_done, 1'b0);
        check_bit("cmd_overflow", cmd_overflow, 1'b0);
        finish_test("reset values", errors_before);

        errors_before = errors;
        run_frame(21'h000100, 1'b0);
        finish_test("full frame", errors_before);

        errors_before = errors;
        run_frame(21'h004000, 1'b1);
        finish_test("stray commands", errors_before);

        errors_before = errors;
        run_frame(21'h1abc0, 1'b0);
        repeat (20) next_cycle();
        if (dones != 3) begin
            errors++;
            $display("upload_done pulsed %0d times over three frames", dones);
        end
        finish_test("done pulse and new base", errors_before);

        errors_before = errors;
        apply_reset();
        repeat (5) send_cmd(CMD_ROW_START);
        next_cycle();
        check_bit("cmd_overflow", cmd_overflow, 1'b1);
        apply_reset();
        repeat (4) send_cmd(CMD_ROW_START);
        next_cycle();
        check_bit("cmd_overflow", cmd_overflow, 1'b0);
        finish_test("command overflow", errors_before);

        $display("%0d tests, %0d beats checked, %0d errors", tests, total_beats, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;   // period 8

endmodule

`default_nettype wire

/* frame_uploader/frame_uploader.sv */
`default_nettype none

module frame_uploader
    import capture_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,
    input  wire           start,
    input  mem_addr_t     base_addr,
    input  wire           cmd_ready,
    input  cmd_t          cmd_head,
    input  word_t         rd_data,
    output logic          cmd_pop,
    output logic          rd_bank,
    output word_index_t   rd_word,
    output logic          upload_done,
    mem_burst_if.uploader mem
);

    uploader_state_t         state;
    row_index_t              row_idx;
    mem_addr_t               read_addr;     // address of the next word to read
    logic                    issue_done;
    logic                    issue;
    logic                    burst_last;
    logic                    cmd_wait;
    logic [READ_LATENCY-1:0] beat_pipe;
    mem_addr_t               addr_pipe [READ_LATENCY];

    assign cmd_wait    = (state == ST_WAIT_FRAME_START) || (state == ST_WAIT_ROW_START) ||
                         (state == ST_WAIT_FRAME_END);
    assign cmd_pop     = cmd_wait && cmd_ready;
    assign issue       = (state == ST_BURST) && !issue_done;
    assign burst_last  = ((int'(rd_word) % BURST_WORDS) == BURST_WORDS - 1);
    assign rd_bank     = row_idx[0];
    assign upload_done = (state == ST_DONE);

    // beat strobe follows the read through the line buffer latency
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_pipe     <= '0;
            mem.mem_wr_en <= 1'b0;
        end else begin
            beat_pipe     <= {beat_pipe[READ_LATENCY-2:0], issue};
            mem.mem_wr_en <= beat_pipe[READ_LATENCY-1];
        end
    end

    always_ff @(posedge clk) begin
        addr_pipe[0] <= read_addr;
        for (int i = 1; i < READ_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
        mem.write_addr <= addr_pipe[READ_LATENCY-1];
        mem.write_data <= rd_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= ST_IDLE;
            row_idx      <= '0;
            rd_word      <= '0;
            read_addr    <= '0;
            issue_done   <= 1'b0;
            mem.write_rq <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        read_addr <= base_addr;
                        row_idx   <= '0;
                        rd_word   <= '0;
                        state     <= ST_WAIT_FRAME_START;
                    end
                end
                ST_WAIT_FRAME_START: begin
                    if (cmd_ready && cmd_head == CMD_FRAME_START) begin
                        state <= ST_WAIT_ROW_START;
                    end
                end
                ST_WAIT_ROW_START: begin
                    if (cmd_ready && cmd_head == CMD_ROW_START) begin
                        mem.write_rq <= 1'b1;
                        state        <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (mem.write_ack) begin
                        issue_done <= 1'b0;
                        state      <= ST_BURST;
                    end
                end
                ST_BURST: begin
                    if (issue) begin
                        rd_word   <= rd_word + 1'b1;
                        read_addr <= read_addr + 1'b1;
                        if (burst_last) begin
                            issue_done <= 1'b1;
                        end
                    end
                    // last beat is on the bus and nothing is left in flight
                    if (issue_done && beat_pipe == '0 && mem.mem_wr_en) begin
                        mem.write_rq <= 1'b0;
                        state        <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!mem.write_ack) begin
                        if (rd_word != '0) begin
                            mem.write_rq <= 1'b1;   // more bursts in this row
                            state        <= ST_REQUEST;
                        end else begin
                            row_idx <= row_idx + 1'b1;
                            state   <= (row_idx == row_index_t'(FRAME_HEIGHT - 1)) ?
                                       ST_WAIT_FRAME_END : ST_WAIT_ROW_START;
                        end
                    end
                end
                ST_WAIT_FRAME_END: begin
                    if (cmd_ready && cmd_head == CMD_FRAME_END) begin
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/capture_top.sv */
`default_nettype none

module capture_top
    import capture_pkg::*;
(
    input  wire       clk,
    input  wire       reset_n,
    input  wire       start,
    input  mem_addr_t base_addr,
    input  wire       pixel_valid,
    input  pixel_t    pixel_data,
    input  wire       cmd_valid,
    input  cmd_t      cmd_code,
    input  wire       write_ack,
    output logic      write_rq,
    output mem_addr_t write_addr,
    output logic      mem_wr_en,
    output word_t     write_data,
    output logic      upload_done,
    output logic      cmd_overflow
);

    logic        cmd_ready;
    cmd_t        cmd_head;
    logic        cmd_pop;
    logic        rd_bank;
    word_index_t rd_word;
    word_t       rd_data;

    mem_burst_if mem_bus ();

    assign mem_bus.write_ack = write_ack;
    assign write_rq          = mem_bus.write_rq;
    assign write_addr        = mem_bus.write_addr;
    assign mem_wr_en         = mem_bus.mem_wr_en;
    assign write_data        = mem_bus.write_data;

    cmd_fifo u_cmd_fifo (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_valid    (cmd_valid),
        .cmd_code     (cmd_code),
        .cmd_pop      (cmd_pop),
        .cmd_ready    (cmd_ready),
        .cmd_head     (cmd_head),
        .cmd_overflow (cmd_overflow)
    );

    line_buffer u_line_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .pixel_valid (pixel_valid),
        .pixel_data  (pixel_data),
        .rd_bank     (rd_bank),
        .rd_word     (rd_word),
        .rd_data     (rd_data)
    );

    frame_uploader u_frame_uploader (
        .clk         (clk),
        .reset_n     (reset_n),
        .start       (start),
        .base_addr   (base_addr),
        .cmd_ready   (cmd_ready),
        .cmd_head    (cmd_head),
        .rd_data     (rd_data),
        .cmd_pop     (cmd_pop),
        .rd_bank     (rd_bank),
        .rd_word     (rd_word),
        .upload_done (upload_done),
        .mem         (mem_bus.uploader)
    );

endmodule

`default_nettype wire

/* logic/cmd_fifo.sv */
`default_nettype none

module cmd_fifo
    import capture_pkg::*;
(
    input  wire  clk,
    input  wire  reset_n,
    input  wire  cmd_valid,
    input  cmd_t cmd_code,
    input  wire  cmd_pop,
    output logic cmd_ready,
    output cmd_t cmd_head,
    output logic cmd_overflow
);

    cmd_t       fifo_mem [CMD_FIFO_DEPTH];
    cmd_ptr_t   wr_ptr;
    cmd_ptr_t   rd_ptr;
    cmd_count_t count;
    logic       full;
    logic       push;
    logic       pop;

    assign full      = (count == cmd_count_t'(CMD_FIFO_DEPTH));
    assign push      = cmd_valid && !full;
    assign pop       = cmd_pop && cmd_ready;
    assign cmd_ready = (count != '0);
    assign cmd_head  = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= cmd_code;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            cmd_overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps since the depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (cmd_valid && full) begin
                cmd_overflow <= 1'b1;      // sticky until reset
            end
        end
    end

endmodule

`default_nettype wire

/* logic/line_buffer.sv */
`default_nettype none

module line_buffer
    import capture_pkg::*;
(
    input  wire         clk,
    input  wire         reset_n,
    input  wire         pixel_valid,
    input  pixel_t      pixel_data,
    input  wire         rd_bank,
    input  word_index_t rd_word,
    output word_t       rd_data
);

    word_t       bank_mem [2][WORDS_PER_ROW];
    word_t       array_q;      // array output register
    pixel_t      low_pixel;    // even pixel waiting for its partner
    logic        pair_phase;
    logic        pair_done;
    logic        wr_bank;
    word_index_t wr_word;

    assign pair_done = pixel_valid && pair_phase;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pair_phase <= 1'b0;
            wr_word    <= '0;
            wr_bank    <= 1'b0;
        end else if (pixel_valid) begin
            pair_phase <= !pair_phase;
            if (pair_done) begin
                wr_word <= wr_word + 1'b1;
                if (wr_word == word_index_t'(WORDS_PER_ROW - 1)) begin
                    wr_bank <= !wr_bank;   // next row goes to the other bank
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_valid && !pair_phase) begin
            low_pixel <= pixel_data;
        end
        if (pair_done) begin
            bank_mem[wr_bank][wr_word] <= {pixel_data, low_pixel};
        end
    end

    // two register stages as in a block RAM with buffered output
    always_ff @(posedge clk) begin
        array_q <= bank_mem[rd_bank][rd_word];
        rd_data <= array_q;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module capture_tb -f sources.f -o capture_sim \
    || exit 1
./obj_dir/capture_sim > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0

/* sources.f */
common/capture_pkg.sv
common/mem_burst_if.sv
logic/cmd_fifo.sv
logic/line_buffer.sv
frame_uploader/frame_uploader.sv
logic/capture_top.sv
dv/tb_clock.sv
dv/capture_sva.sv
dv/capture_tb.sv
